// ==== include/r2b_macros.svh ====
`ifndef R2B_MACROS_SVH
`define R2B_MACROS_SVH

// Fixed-point element format
`define R2B_WIDTH       16
`define R2B_FRAC_WIDTH  8

// Weight matrix size
`define R2B_ROW         8
`define R2B_COL         4

// Square block edge
`define R2B_BLOCK       2

// Accumulator width
`define R2B_ACC_WIDTH   32

`endif

// ==== hw/r2b_data_pkg.sv ====
`include "r2b_macros.svh"

package r2b_data_pkg;

    // One signed fixed-point weight or activation
    typedef logic signed [`R2B_WIDTH-1:0] elem_t;

    // Full matrix row, element j in slot j
    typedef elem_t [`R2B_COL-1:0] row_t;

    // Block slot = col_in_block * BLOCK + row_in_block
    typedef elem_t [`R2B_BLOCK*`R2B_BLOCK-1:0] block_t;

    // Wrapping accumulator
    typedef logic signed [`R2B_ACC_WIDTH-1:0] acc_t;

endpackage

// ==== hw/r2b_ctrl_pkg.sv ====
`include "r2b_macros.svh"

package r2b_ctrl_pkg;

    typedef enum logic [1:0] {
        CONV_IDLE,
        CONV_FILL,
        CONV_PROCESS,
        CONV_DONE
    } conv_state_t;

    typedef logic [$clog2(`R2B_ROW)-1:0] row_idx_t;

    typedef logic [$clog2(`R2B_ROW/`R2B_BLOCK)-1:0] blk_row_t;

    typedef logic [$clog2(`R2B_COL/`R2B_BLOCK)-1:0] col_grp_t;

endpackage

// ==== hw/weight_row_packer.sv ====
`timescale 1ns/1ns
`include "r2b_macros.svh"

module weight_row_packer
    import r2b_data_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  elem_valid,
    input  elem_t elem_data,
    output row_t  row_data,
    output logic  row_valid
);

    localparam int COL_W = $clog2(`R2B_COL);

    logic [COL_W-1:0] col_cnt;
    logic             row_full;

    assign row_full = (col_cnt == COL_W'(`R2B_COL - 1));

    // Column counter and row strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt   <= '0;
            row_valid <= 1'b0;
        end else begin
            row_valid <= elem_valid && row_full;
            if (elem_valid) begin
                if (row_full) begin
                    col_cnt <= '0;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    // Each element lands in its own column slot
    always_ff @(posedge clk) begin
        if (elem_valid) begin
            row_data[col_cnt] <= elem_data;
        end
    end

endmodule

// ==== hw/ram_1w2r.sv ====
`timescale 1ns/1ns

module ram_1w2r #(
    parameter int DATA_WIDTH = 64,
    parameter int DEPTH      = 8
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] write_addr,
    input  logic [$clog2(DEPTH)-1:0] read_addr0,
    input  logic [$clog2(DEPTH)-1:0] read_addr1,
    input  logic [DATA_WIDTH-1:0]    din,
    output logic [DATA_WIDTH-1:0]    dout0,
    output logic [DATA_WIDTH-1:0]    dout1
);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[write_addr] <= din;
        end
    end

    // Both read ports are combinational
    assign dout0 = mem[read_addr0];
    assign dout1 = mem[read_addr1];

endmodule

// ==== hw/r2b_converter.sv ====
`timescale 1ns/1ns
`include "r2b_macros.svh"

module r2b_converter
    import r2b_data_pkg::*;
    import r2b_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   en,
    input  logic   row_valid,
    input  row_t   row_data,
    output block_t block_data,
    output logic   output_ready,
    output logic   slice_done,
    output logic   slice_last,
    output logic   buffer_done
);

    localparam int TOTAL_BLOCKS = `R2B_ROW / `R2B_BLOCK;
    localparam int COL_GROUPS   = `R2B_COL / `R2B_BLOCK;

    conv_state_t state;
    conv_state_t state_next;

    row_idx_t row_cnt;
    blk_row_t blk_row;
    col_grp_t col_grp;

    logic     ram_we;
    row_idx_t ram_read_addr0;
    row_idx_t ram_read_addr1;
    row_t     ram_dout0;
    row_t     ram_dout1;

    logic in_process;
    logic last_row;
    logic last_blk_row;
    logic last_col_grp;

    assign in_process   = (state == CONV_PROCESS);
    assign last_row     = (row_cnt == row_idx_t'(`R2B_ROW - 1));
    assign last_blk_row = (blk_row == blk_row_t'(TOTAL_BLOCKS - 1));
    assign last_col_grp = (col_grp == col_grp_t'(COL_GROUPS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= CONV_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            CONV_IDLE: begin
                if (en) begin
                    state_next = CONV_FILL;
                end
            end
            CONV_FILL: begin
                if (row_valid && last_row) begin
                    state_next = CONV_PROCESS;
                end
            end
            CONV_PROCESS: begin
                if (last_blk_row && last_col_grp) begin
                    state_next = CONV_DONE;
                end
            end
            CONV_DONE: state_next = CONV_IDLE;
            default:   state_next = CONV_IDLE;
        endcase
    end

    // Rows outside fill are dropped
    assign ram_we = (state == CONV_FILL) && row_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_cnt <= '0;
        end else if (ram_we) begin
            row_cnt <= last_row ? '0 : row_cnt + 1'b1;
        end
    end

    // Block row walks fastest, then column group
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blk_row <= '0;
            col_grp <= '0;
        end else if (in_process) begin
            if (last_blk_row) begin
                blk_row <= '0;
                col_grp <= last_col_grp ? '0 : col_grp + 1'b1;
            end else begin
                blk_row <= blk_row + 1'b1;
            end
        end
    end

    assign ram_read_addr0 = {blk_row, 1'b0};
    assign ram_read_addr1 = {blk_row, 1'b1};

    // Gather the two columns of the group into block order
    always_ff @(posedge clk) begin
        if (in_process) begin
            for (int k = 0; k < `R2B_BLOCK; k++) begin
                block_data[k*`R2B_BLOCK]     <= ram_dout0[int'(col_grp)*`R2B_BLOCK + k];
                block_data[k*`R2B_BLOCK + 1] <= ram_dout1[int'(col_grp)*`R2B_BLOCK + k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            output_ready <= 1'b0;
            slice_done   <= 1'b0;
            slice_last   <= 1'b0;
        end else begin
            output_ready <= in_process;
            slice_done   <= in_process && last_blk_row;
            slice_last   <= in_process && last_blk_row && last_col_grp;
        end
    end

    // Lines up with the final output_ready
    assign buffer_done = (state == CONV_DONE);

    ram_1w2r #(
        .DATA_WIDTH ($bits(row_t)),
        .DEPTH      (`R2B_ROW)
    ) i_row_ram (
        .clk        (clk),
        .we         (ram_we),
        .write_addr (row_cnt),
        .read_addr0 (ram_read_addr0),
        .read_addr1 (ram_read_addr1),
        .din        (row_data),
        .dout0      (ram_dout0),
        .dout1      (ram_dout1)
    );

endmodule

// ==== hw/block_vecmat_core.sv ====
`timescale 1ns/1ns
`include "r2b_macros.svh"

module block_vecmat_core
    import r2b_data_pkg::*;
    import r2b_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     act_we,
    input  row_idx_t act_addr,
    input  elem_t    act_data,
    input  block_t   block_data,
    input  logic     output_ready,
    input  logic     slice_done,
    input  logic     slice_last,
    output logic     result_valid,
    output logic     result_last,
    output col_grp_t result_col,
    output acc_t     result_y0,
    output acc_t     result_y1
);

    elem_t act [`R2B_ROW];

    blk_row_t blk_row;
    col_grp_t col_grp;

    elem_t x_top;
    elem_t x_bot;
    acc_t  prod [4];
    acc_t  sum0;
    acc_t  sum1;
    acc_t  acc0;
    acc_t  acc1;

    always_ff @(posedge clk) begin
        if (act_we) begin
            act[act_addr] <= act_data;
        end
    end

    // Local position in the block stream
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blk_row <= '0;
            col_grp <= '0;
        end else if (output_ready) begin
            if (slice_done) begin
                blk_row <= '0;
                col_grp <= col_grp + 1'b1;
            end else begin
                blk_row <= blk_row + 1'b1;
            end
        end
    end

    assign x_top = act[{blk_row, 1'b0}];
    assign x_bot = act[{blk_row, 1'b1}];

    // Products in Q format, shifted back to element scale
    always_comb begin
        prod[0] = (x_top * elem_t'(block_data[0])) >>> `R2B_FRAC_WIDTH;
        prod[1] = (x_bot * elem_t'(block_data[1])) >>> `R2B_FRAC_WIDTH;
        prod[2] = (x_top * elem_t'(block_data[2])) >>> `R2B_FRAC_WIDTH;
        prod[3] = (x_bot * elem_t'(block_data[3])) >>> `R2B_FRAC_WIDTH;
        sum0    = prod[0] + prod[1];
        sum1    = prod[2] + prod[3];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc0 <= '0;
            acc1 <= '0;
        end else if (output_ready) begin
            if (slice_done) begin
                acc0 <= '0;
                acc1 <= '0;
            end else begin
                acc0 <= acc0 + sum0;
                acc1 <= acc1 + sum1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result_last  <= 1'b0;
        end else begin
            result_valid <= slice_done;
            result_last  <= slice_done && slice_last;
        end
    end

    // Final sums include the closing block
    always_ff @(posedge clk) begin
        if (slice_done) begin
            result_y0  <= acc0 + sum0;
            result_y1  <= acc1 + sum1;
            result_col <= col_grp;
        end
    end

endmodule

// ==== hw/weight_stream_top.sv ====
`timescale 1ns/1ns

module weight_stream_top
    import r2b_data_pkg::*;
    import r2b_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     elem_valid,
    input  elem_t    elem_data,
    input  logic     act_we,
    input  row_idx_t act_addr,
    input  elem_t    act_data,
    output logic     result_valid,
    output col_grp_t result_col,
    output acc_t     result_y0,
    output acc_t     result_y1,
    output logic     result_last,
    output logic     buffer_done
);

    row_t   row_data;
    logic   row_valid;
    block_t block_data;
    logic   output_ready;
    logic   slice_done;
    logic   slice_last;

    weight_row_packer i_packer (
        .clk        (clk),
        .rst_n      (rst_n),
        .elem_valid (elem_valid),
        .elem_data  (elem_data),
        .row_data   (row_data),
        .row_valid  (row_valid)
    );

    r2b_converter i_converter (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .row_valid    (row_valid),
        .row_data     (row_data),
        .block_data   (block_data),
        .output_ready (output_ready),
        .slice_done   (slice_done),
        .slice_last   (slice_last),
        .buffer_done  (buffer_done)
    );

    block_vecmat_core i_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .act_we       (act_we),
        .act_addr     (act_addr),
        .act_data     (act_data),
        .block_data   (block_data),
        .output_ready (output_ready),
        .slice_done   (slice_done),
        .slice_last   (slice_last),
        .result_valid (result_valid),
        .result_last  (result_last),
        .result_col   (result_col),
        .result_y0    (result_y0),
        .result_y1    (result_y1)
    );

endmodule

// ==== verification/tb_weight_stream.sv ====
`timescale 1ns/1ns
`include "r2b_macros.svh"

module tb_weight_stream
    import r2b_data_pkg::*;
    import r2b_ctrl_pkg::*;
();

    localparam int COL_GROUPS = `R2B_COL / `R2B_BLOCK;
    localparam int PASS_WORDS = `R2B_ROW + `R2B_ROW * `R2B_COL + 2 * COL_GROUPS;
    localparam int NUM_PASSES = 2;
    localparam int TIMEOUT    = 200;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     en;
    logic     elem_valid;
    elem_t    elem_data;
    logic     act_we;
    row_idx_t act_addr;
    elem_t    act_data;
    logic     result_valid;
    col_grp_t result_col;
    acc_t     result_y0;
    acc_t     result_y1;
    logic     result_last;
    logic     buffer_done;

    logic [31:0] testdata [NUM_PASSES * PASS_WORDS];
    logic [31:0] lfsr_state;
    int          pass_base;
    int          result_count;
    int          done_count;

    weight_stream_top i_dut (.*);

    always #10 clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input int got, input int expected);
        stop_with_failure($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                                    $time, name, got, expected));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic random_bits(input int count, output int value);
        value = 0;
        repeat (count) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic next_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic check_result();
        int idx;
        assert (result_count < COL_GROUPS)
            else stop_with_failure("More than two results came out in one pass");
        // Expected pairs sit at the end of each pass
        idx = pass_base + PASS_WORDS - 2 * COL_GROUPS + 2 * result_count;
        assert (result_col == col_grp_t'(result_count))
            else report_mismatch("result_col", int'(result_col), result_count);
        assert (result_y0 == acc_t'(testdata[idx]))
            else report_mismatch("result_y0", result_y0, testdata[idx]);
        assert (result_y1 == acc_t'(testdata[idx + 1]))
            else report_mismatch("result_y1", result_y1, testdata[idx + 1]);
        assert (result_last == (result_count == COL_GROUPS - 1))
            else report_mismatch("result_last", int'(result_last),
                                 int'(result_count == COL_GROUPS - 1));
    endtask

    // Sampled on the falling edge, away from the registered outputs
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            check_result();
            result_count++;
        end
        if (rst_n && buffer_done) begin
            done_count++;
            assert (result_count < COL_GROUPS)
                else stop_with_failure("buffer_done came after the last result of the pass");
        end
    end

    task automatic run_pass(input int pass);
        int gap;
        int wait_cycles;
        pass_base    = pass * PASS_WORDS;
        result_count = 0;
        done_count   = 0;
        for (int i = 0; i < `R2B_ROW; i++) begin
            next_slot();
            act_we   = 1'b1;
            act_addr = row_idx_t'(i);
            act_data = elem_t'(testdata[pass_base + i]);
        end
        next_slot();
        act_we = 1'b0;
        en     = 1'b1;
        next_slot();
        en = 1'b0;
        // Row-major weights, idle gaps only in later passes
        for (int k = 0; k < `R2B_ROW * `R2B_COL; k++) begin
            next_slot();
            elem_valid = 1'b1;
            elem_data  = elem_t'(testdata[pass_base + `R2B_ROW + k]);
            gap = 0;
            if (pass > 0) begin
                random_bits(2, gap);
            end
            if (gap > 0) begin
                next_slot();
                elem_valid = 1'b0;
                repeat (gap - 1) next_slot();
            end
        end
        next_slot();
        elem_valid  = 1'b0;
        wait_cycles = 0;
        while (result_count < COL_GROUPS) begin
            next_slot();
            wait_cycles++;
            assert (wait_cycles < TIMEOUT)
                else stop_with_failure($sformatf("Timeout in pass %0d: %0d of %0d results arrived",
                                                 pass + 1, result_count, COL_GROUPS));
        end
        // Quiet tail so a stray result or pulse is still seen
        repeat (8) next_slot();
        assert (done_count == 1)
            else stop_with_failure($sformatf("buffer_done pulsed %0d times in pass %0d",
                                             done_count, pass + 1));
    endtask

    initial begin
        rst_n        = 1'b0;
        en           = 1'b0;
        elem_valid   = 1'b0;
        elem_data    = '0;
        act_we       = 1'b0;
        act_addr     = '0;
        act_data     = '0;
        lfsr_state   = 32'hd081d00c;
        pass_base    = 0;
        result_count = 0;
        done_count   = 0;
        $readmemh("verification/vecmat_testdata.mem", testdata);
        assert (!$isunknown(testdata[NUM_PASSES * PASS_WORDS - 1]))
            else stop_with_failure("Test data file is missing or too short");
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // Nothing may come out before en
        repeat (10) begin
            next_slot();
            assert (!result_valid && !result_last && !buffer_done)
                else stop_with_failure("Outputs were active before the converter was started");
        end
        for (int pass = 0; pass < NUM_PASSES; pass++) begin
            run_pass(pass);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== verification/vecmat_testdata.mem ====
// Per pass: one line of 8 activations x[0..7], eight lines of weights W[i][0..3],
// then expected y0 y1 of column group 0 followed by y0 y1 of column group 1
// Pass 1
0100 0080 FF00 0200 0040 FFC0 0180 0010
0100 0200 FF80 0040
0080 FF00 0180 0020
0040 0080 0100 FE00
FFC0 0020 0010 0100
0200 FE80 0064 00C8
012C 0100 FFCE 0080
FF00 0040 00C0 000A
03E8 FC18 004D FFFD
FFFFFF73 000000C1 000000A9 00000470
// Pass 2
FF80 0300 0020 FE00 00C8 0001 FFFF 0100
0064 FF38 012C FE70
0007 000F FFF7 03E8
0320 FCE0 0040 0000
0003 FFFD 0081 FF7F
0100 0080 FF00 0280
1388 EC78 0100 0001
0001 0100 FEFF 03E8
FFF9 0013 007B FE38
00000114 00000095 FFFFFE0A 00000DAA

// ==== filelist.f ====
+incdir+include
hw/r2b_data_pkg.sv
hw/r2b_ctrl_pkg.sv
hw/weight_row_packer.sv
hw/ram_1w2r.sv
hw/r2b_converter.sv
hw/block_vecmat_core.sv
hw/weight_stream_top.sv
verification/tb_weight_stream.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
TOP      := tb_weight_stream
FILELIST := filelist.f
OBJ_DIR  := obj_dir
PASS_MSG := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F "$(PASS_MSG)"

lint:
	$(SIM) --lint-only -Wall --timing --timescale 1ns/1ns --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
